// File: rtl/cu_setup_params.svh
// CU setup parameters: address, line, counter and request FIFO sizing
`ifndef CU_SETUP_PARAMS_SVH
`define CU_SETUP_PARAMS_SVH

// ---------------------------------------------------------------------------
// Memory geometry
// ---------------------------------------------------------------------------
// Byte address width
`define CU_ADDR_W 64
// Cache line width in bits, one read request per line
`define CU_LINE_W 512

// Array size and index width
`define CU_COUNTER_W 32

// ---------------------------------------------------------------------------
// Request FIFO
// ---------------------------------------------------------------------------
`define CU_FIFO_DEPTH 32
// Occupancy that raises prog_full, leaves half the depth as margin
`define CU_FIFO_PROG_THRESH 16

// ---------------------------------------------------------------------------
// Serial read walk
// ---------------------------------------------------------------------------
`define CU_READ_STRIDE (`CU_COUNTER_W'(1))
`define CU_READ_START (`CU_COUNTER_W'(0))

`endif

// File: rtl/cu_setup_pkg.sv
// CU setup types: descriptor, read configuration, request, FIFO state and FSM states
`include "cu_setup_params.svh"

package cu_setup_pkg;

    // Width of the line shift amount
    localparam int CU_SHIFT_W = $clog2(`CU_ADDR_W);

    // -----------------------------------------------------------------------
    // Kernel descriptor from the host
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic                     valid;
        logic [`CU_ADDR_W-1:0]    base_address;
        logic [`CU_COUNTER_W-1:0] array_size;
    } cu_descriptor_t;

    // Serial read engine configuration
    typedef struct packed {
        logic [`CU_ADDR_W-1:0]    base_address;
        logic [`CU_COUNTER_W-1:0] start_index;
        logic [`CU_COUNTER_W-1:0] end_index;
        logic [`CU_COUNTER_W-1:0] stride;
        logic [CU_SHIFT_W-1:0]    line_shift;
    } read_config_t;

    // -----------------------------------------------------------------------
    // Memory side
    // -----------------------------------------------------------------------
    // One cache-line read request
    typedef struct packed {
        logic                  valid;
        logic [`CU_ADDR_W-1:0] address;
    } mem_request_t;

    // Request FIFO occupancy flags
    typedef struct packed {
        logic empty;
        logic full;
        logic prog_full;
    } fifo_state_t;

    // -----------------------------------------------------------------------
    // Setup FSM
    // -----------------------------------------------------------------------
    typedef enum logic [2:0] {
        RESET,
        IDLE,
        REQ_START,
        REQ_BUSY,
        REQ_PAUSE,
        REQ_DONE
    } cu_setup_state_t;

endpackage

// File: rtl/cu_setup_config.sv
// CU setup config: captures the kernel descriptor and builds the read configuration
`timescale 1ns/1ps
`include "cu_setup_params.svh"

module cu_setup_config (
    input  logic                        ap_clk,
    input  logic                        areset_cu_setup,
    input  cu_setup_pkg::cu_descriptor_t descriptor,
    output logic                        descriptor_valid,
    output cu_setup_pkg::read_config_t  read_config
);

    // Byte offset bits of one cache line
    localparam int LINE_SHIFT = $clog2(`CU_LINE_W / 8);

    cu_setup_pkg::cu_descriptor_t descriptor_reg;

    // Input register, only valid is cleared
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            descriptor_reg.valid <= 1'b0;
        end else begin
            descriptor_reg.valid <= descriptor.valid;
        end
        descriptor_reg.base_address <= descriptor.base_address;
        descriptor_reg.array_size   <= descriptor.array_size;
    end

    assign descriptor_valid = descriptor_reg.valid;

    // Configuration follows the captured payload one cycle later
    always_ff @(posedge ap_clk) begin
        read_config.base_address <= descriptor_reg.base_address;
        read_config.start_index  <= `CU_READ_START;
        read_config.end_index    <= descriptor_reg.array_size;
        read_config.stride       <= `CU_READ_STRIDE;
        read_config.line_shift   <= LINE_SHIFT[cu_setup_pkg::CU_SHIFT_W-1:0];
    end

endmodule

// File: rtl/cu_setup_fsm.sv
// CU setup FSM: runs one serial read pass per descriptor with FIFO back-pressure
`timescale 1ns/1ps

module cu_setup_fsm (
    input  logic                     ap_clk,
    input  logic                     areset_cu_setup,
    input  logic                     descriptor_valid,
    input  logic                     engine_ready,
    input  logic                     engine_done,
    input  cu_setup_pkg::fifo_state_t fifo_state,
    output logic                     engine_start,
    output logic                     engine_pause
);

    cu_setup_pkg::cu_setup_state_t current_state;
    cu_setup_pkg::cu_setup_state_t next_state;

    // Engine finished and every request has left the FIFO
    logic done_flag;

    // -----------------------------------------------------------------------
    // State register
    // -----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            current_state <= cu_setup_pkg::RESET;
        end else begin
            current_state <= next_state;
        end
    end

    // -----------------------------------------------------------------------
    // Next state
    // -----------------------------------------------------------------------
    always_comb begin
        next_state = current_state;
        case (current_state)
            cu_setup_pkg::RESET: begin
                next_state = cu_setup_pkg::IDLE;
            end
            cu_setup_pkg::IDLE: begin
                if (descriptor_valid && engine_ready && engine_done) begin
                    next_state = cu_setup_pkg::REQ_START;
                end
            end
            cu_setup_pkg::REQ_START: begin
                // Wait for the engine to take the start
                if (!engine_ready && !engine_done) begin
                    next_state = cu_setup_pkg::REQ_BUSY;
                end
            end
            cu_setup_pkg::REQ_BUSY: begin
                if (done_flag) begin
                    next_state = cu_setup_pkg::REQ_DONE;
                end else if (fifo_state.prog_full) begin
                    next_state = cu_setup_pkg::REQ_PAUSE;
                end
            end
            cu_setup_pkg::REQ_PAUSE: begin
                if (!fifo_state.prog_full) begin
                    next_state = cu_setup_pkg::REQ_BUSY;
                end
            end
            cu_setup_pkg::REQ_DONE: begin
                // Host must drop valid before the next descriptor
                if (!descriptor_valid) begin
                    next_state = cu_setup_pkg::IDLE;
                end
            end
            default: begin
                next_state = cu_setup_pkg::RESET;
            end
        endcase
    end

    // -----------------------------------------------------------------------
    // Registered outputs, aligned with the state register
    // -----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            engine_start <= 1'b0;
            engine_pause <= 1'b0;
            done_flag    <= 1'b0;
        end else begin
            engine_start <= (next_state == cu_setup_pkg::REQ_START);
            engine_pause <= (next_state == cu_setup_pkg::REQ_PAUSE);
            done_flag    <= (current_state == cu_setup_pkg::REQ_BUSY) &&
                            engine_done && fifo_state.empty;
        end
    end

endmodule

// File: rtl/serial_read_engine.sv
// Serial read engine: walks an index range and issues one cache-line read per index
`timescale 1ns/1ps
`include "cu_setup_params.svh"

module serial_read_engine (
    input  logic                      ap_clk,
    input  logic                      areset_cu_setup,
    input  cu_setup_pkg::read_config_t read_config,
    input  logic                      start,
    input  logic                      pause,
    output logic                      ready,
    output logic                      done,
    output cu_setup_pkg::mem_request_t request
);

    logic                     running;
    logic [`CU_COUNTER_W-1:0] index;
    logic [`CU_ADDR_W-1:0]    line_offset;
    logic                     last_reached;

    // Byte offset of the current line
    assign line_offset  = `CU_ADDR_W'(index) << read_config.line_shift;
    assign last_reached = (index >= read_config.end_index);

    // -----------------------------------------------------------------------
    // Control
    // -----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            running       <= 1'b0;
            ready         <= 1'b1;
            done          <= 1'b1;
            request.valid <= 1'b0;
        end else begin
            request.valid <= 1'b0;
            if (!running) begin
                // Start only counts while idle
                if (start && ready) begin
                    running <= 1'b1;
                    ready   <= 1'b0;
                    done    <= 1'b0;
                end
            end else if (!pause) begin
                if (last_reached) begin
                    running <= 1'b0;
                    ready   <= 1'b1;
                    done    <= 1'b1;
                end else begin
                    request.valid <= 1'b1;
                end
            end
        end
    end

    // -----------------------------------------------------------------------
    // Index and address
    // -----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (!running) begin
            if (start && ready) begin
                index <= read_config.start_index;
            end
        end else if (!pause && !last_reached) begin
            index           <= index + read_config.stride;
            request.address <= read_config.base_address + line_offset;
        end
    end

endmodule

// File: rtl/request_fifo.sv
// Request FIFO: synchronous circular buffer of read requests with prog-full flag
`timescale 1ns/1ps
`include "cu_setup_params.svh"

module request_fifo (
    input  logic                      ap_clk,
    input  logic                      areset_cu_setup,
    input  cu_setup_pkg::mem_request_t push,
    input  logic                      pop,
    output cu_setup_pkg::mem_request_t pop_data,
    output cu_setup_pkg::fifo_state_t  state,
    output logic                      reset_busy
);

    localparam int PTR_W = $clog2(`CU_FIFO_DEPTH);

    logic [`CU_ADDR_W-1:0] mem [`CU_FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W:0]        count;
    logic                  push_take;
    logic                  pop_take;

    assign push_take = push.valid && !state.full;
    assign pop_take  = pop && !state.empty;

    // Flags straight from the occupancy count
    assign state.empty     = (count == '0);
    assign state.full      = (count == `CU_FIFO_DEPTH);
    assign state.prog_full = (count >= `CU_FIFO_PROG_THRESH);

    // -----------------------------------------------------------------------
    // Pointers and count
    // -----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_take) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_take, pop_take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (push_take) begin
            mem[wr_ptr] <= push.address;
        end
    end

    // -----------------------------------------------------------------------
    // Read port, data one cycle after the pop
    // -----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            pop_data.valid <= 1'b0;
            reset_busy     <= 1'b1;
        end else begin
            pop_data.valid <= pop_take;
            reset_busy     <= 1'b0;
        end
        if (pop_take) begin
            pop_data.address <= mem[rd_ptr];
        end
    end

endmodule

// File: rtl/cu_setup.sv
// CU setup top: turns a kernel descriptor into a FIFO-buffered stream of line reads
`timescale 1ns/1ps

module cu_setup (
    input  logic                         ap_clk,
    input  logic                         areset_cu_setup,
    input  cu_setup_pkg::cu_descriptor_t descriptor,
    input  logic                         request_pop,
    output cu_setup_pkg::mem_request_t   request_out,
    output cu_setup_pkg::fifo_state_t    request_fifo_state,
    output logic                         setup_busy
);

    // Registered reset copies, one per block
    logic areset_top;
    logic areset_config;
    logic areset_fsm;
    logic areset_engine;
    logic areset_fifo;

    logic                       request_pop_reg;
    logic                       descriptor_valid;
    cu_setup_pkg::read_config_t read_config;
    logic                       engine_start;
    logic                       engine_pause;
    logic                       engine_ready;
    logic                       engine_done;
    cu_setup_pkg::mem_request_t engine_request;
    cu_setup_pkg::mem_request_t fifo_pop_data;
    cu_setup_pkg::fifo_state_t  fifo_state;
    logic                       fifo_reset_busy;

    // -----------------------------------------------------------------------
    // Reset distribution
    // -----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_top    <= areset_cu_setup;
        areset_config <= areset_cu_setup;
        areset_fsm    <= areset_cu_setup;
        areset_engine <= areset_cu_setup;
        areset_fifo   <= areset_cu_setup;
    end

    // Pop level input register, descriptor is captured in the config block
    always_ff @(posedge ap_clk) begin
        if (areset_top) begin
            request_pop_reg <= 1'b0;
        end else begin
            request_pop_reg <= request_pop;
        end
    end

    // -----------------------------------------------------------------------
    // Output registers
    // -----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_top) begin
            request_out.valid <= 1'b0;
            setup_busy        <= 1'b1;
        end else begin
            request_out.valid <= fifo_pop_data.valid;
            setup_busy        <= fifo_reset_busy;
        end
        request_out.address <= fifo_pop_data.address;
        request_fifo_state  <= fifo_state;
    end

    // -----------------------------------------------------------------------
    // Blocks
    // -----------------------------------------------------------------------
    cu_setup_config i_cu_setup_config (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_config),
        .descriptor      (descriptor),
        .descriptor_valid(descriptor_valid),
        .read_config     (read_config)
    );

    cu_setup_fsm i_cu_setup_fsm (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_fsm),
        .descriptor_valid(descriptor_valid),
        .engine_ready    (engine_ready),
        .engine_done     (engine_done),
        .fifo_state      (fifo_state),
        .engine_start    (engine_start),
        .engine_pause    (engine_pause)
    );

    serial_read_engine i_serial_read_engine (
        .ap_clk         (ap_clk),
        .areset_cu_setup(areset_engine),
        .read_config    (read_config),
        .start          (engine_start),
        .pause          (engine_pause),
        .ready          (engine_ready),
        .done           (engine_done),
        .request        (engine_request)
    );

    request_fifo i_request_fifo (
        .ap_clk         (ap_clk),
        .areset_cu_setup(areset_fifo),
        .push           (engine_request),
        .pop            (request_pop_reg),
        .pop_data       (fifo_pop_data),
        .state          (fifo_state),
        .reset_busy     (fifo_reset_busy)
    );

endmodule

// File: verif/tb_cu_setup.sv
// Directed testbench for the CU setup unit with back-pressure and random drain passes
`timescale 1ns/1ps
`include "cu_setup_params.svh"

module tb_cu_setup;

    localparam int LINE_BYTES    = `CU_LINE_W / 8;
    // Array sizes of every pass in the sequence below
    localparam int TOTAL_SIZE    = 5 + 40 + 4 + 4 + 0 + 3 + 64;
    localparam int TIMEOUT_LIMIT = TOTAL_SIZE * 8 + 2000;

    logic                         ap_clk;
    logic                         areset_cu_setup;
    cu_setup_pkg::cu_descriptor_t descriptor;
    logic                         request_pop;
    cu_setup_pkg::mem_request_t   request_out;
    cu_setup_pkg::fifo_state_t    request_fifo_state;
    logic                         setup_busy;

    cu_setup_pkg::mem_request_t seen_q[$];
    logic [31:0]                lfsr_state = 32'h7ea4;
    int                         cycle_count = 0;
    logic                       drain_done;

    cu_setup i_cu_setup (
        .ap_clk            (ap_clk),
        .areset_cu_setup   (areset_cu_setup),
        .descriptor        (descriptor),
        .request_pop       (request_pop),
        .request_out       (request_out),
        .request_fifo_state(request_fifo_state),
        .setup_busy        (setup_busy)
    );

    initial begin
        ap_clk = 1'b0;
        forever #4 ap_clk = ~ap_clk;
    end

    // Scoreboard capture of every request leaving the DUT
    always @(posedge ap_clk) begin
        if (request_out.valid === 1'b1) begin
            seen_q.push_back(request_out);
        end
    end

    always @(posedge ap_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_LIMIT) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
            stop_failed();
        end
    end

    // ------------------------------------------------------------------------
    // Failure and compare helpers
    // ------------------------------------------------------------------------
    task automatic stop_failed();
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_request(input cu_setup_pkg::mem_request_t got,
                                 input cu_setup_pkg::mem_request_t exp, input string name);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got valid=%b address=%h expected valid=%b address=%h",
                     $time, name, got.valid, got.address, exp.valid, exp.address);
            stop_failed();
        end
    endtask

    task automatic check_fifo_state(input cu_setup_pkg::fifo_state_t got,
                                    input cu_setup_pkg::fifo_state_t exp, input string name);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got empty=%b full=%b prog_full=%b expected %b %b %b",
                     $time, name, got.empty, got.full, got.prog_full,
                     exp.empty, exp.full, exp.prog_full);
            stop_failed();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_failed();
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback  = state[31] ^ state[21] ^ state[1] ^ state[0];
        lfsr_step = {state[30:0], feedback};
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus and scoreboard tasks
    // ------------------------------------------------------------------------
    task automatic drive_descriptor(input logic [63:0] base, input logic [31:0] size);
        @(negedge ap_clk);
        descriptor.valid        = 1'b1;
        descriptor.base_address = base;
        descriptor.array_size   = size;
    endtask

    // Valid low long enough for the FSM to return to IDLE
    task automatic release_descriptor();
        @(negedge ap_clk);
        descriptor.valid = 1'b0;
        repeat (8) @(negedge ap_clk);
    endtask

    task automatic collect_requests(input logic [63:0] base, input int count);
        cu_setup_pkg::mem_request_t expected;
        for (int i = 0; i < count; i++) begin
            while (seen_q.size() == 0) @(negedge ap_clk);
            expected.valid   = 1'b1;
            expected.address = base + 64'(i) * LINE_BYTES;
            check_request(seen_q.pop_front(), expected, "request_out");
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge ap_clk);
            check_flag(request_out.valid, 1'b0, "request_out.valid");
        end
        if (seen_q.size() != 0) begin
            $display("Unexpected extra request at address %h", seen_q[0].address);
            stop_failed();
        end
    endtask

    task automatic wait_fifo_empty();
        while (request_fifo_state.empty !== 1'b1) @(negedge ap_clk);
        check_fifo_state(request_fifo_state, '{empty: 1'b1, full: 1'b0, prog_full: 1'b0},
                         "request_fifo_state");
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic test_reset();
        int wait_cycles;
        repeat (16) @(negedge ap_clk);
        check_flag(setup_busy, 1'b1, "setup_busy");
        check_flag(request_out.valid, 1'b0, "request_out.valid");
        areset_cu_setup = 1'b0;
        wait_cycles = 0;
        while (setup_busy !== 1'b0 && wait_cycles < 10) begin
            @(negedge ap_clk);
            check_flag(request_out.valid, 1'b0, "request_out.valid");
            wait_cycles++;
        end
        if (setup_busy !== 1'b0) begin
            $display("setup_busy stayed high 10 cycles after reset release");
            stop_failed();
        end
        check_fifo_state(request_fifo_state, '{empty: 1'b1, full: 1'b0, prog_full: 1'b0},
                         "request_fifo_state");
    endtask

    task automatic test_single_pass();
        @(negedge ap_clk);
        request_pop = 1'b1;
        drive_descriptor(64'h1000, 5);
        collect_requests(64'h1000, 5);
        expect_quiet(100);
        release_descriptor();
    endtask

    task automatic test_back_pressure();
        @(negedge ap_clk);
        request_pop = 1'b0;
        drive_descriptor(64'h2_0000, 40);
        while (request_fifo_state.prog_full !== 1'b1) @(negedge ap_clk);
        // Engine pause settles within a few cycles
        repeat (10) @(negedge ap_clk);
        if (seen_q.size() != 0) begin
            $display("A request left the DUT while request_pop was low");
            stop_failed();
        end
        check_fifo_state(request_fifo_state, '{empty: 1'b0, full: 1'b0, prog_full: 1'b1},
                         "request_fifo_state");
        check_flag(request_out.valid, 1'b0, "request_out.valid");
        request_pop = 1'b1;
        collect_requests(64'h2_0000, 40);
        wait_fifo_empty();
        expect_quiet(20);
        release_descriptor();
    endtask

    task automatic test_held_descriptor();
        drive_descriptor(64'h4_0000, 4);
        collect_requests(64'h4_0000, 4);
        expect_quiet(100);
        release_descriptor();
        drive_descriptor(64'h5_0000, 4);
        collect_requests(64'h5_0000, 4);
        expect_quiet(20);
        release_descriptor();
    endtask

    task automatic test_empty_array();
        drive_descriptor(64'h6000, 0);
        expect_quiet(100);
        release_descriptor();
        drive_descriptor(64'h7000, 3);
        collect_requests(64'h7000, 3);
        expect_quiet(20);
        release_descriptor();
    endtask

    task automatic test_random_drain();
        drain_done = 1'b0;
        drive_descriptor(64'h9_0000, 64);
        fork
            begin
                collect_requests(64'h9_0000, 64);
                drain_done = 1'b1;
            end
            begin
                while (!drain_done) begin
                    @(negedge ap_clk);
                    lfsr_state  = lfsr_step(lfsr_state);
                    request_pop = lfsr_state[0];
                end
            end
        join
        @(negedge ap_clk);
        request_pop = 1'b1;
        wait_fifo_empty();
        expect_quiet(20);
        release_descriptor();
    endtask

    initial begin
        areset_cu_setup = 1'b1;
        request_pop     = 1'b0;
        descriptor      = '0;
        drain_done      = 1'b0;
        test_reset();
        test_single_pass();
        test_back_pressure();
        test_held_descriptor();
        test_empty_array();
        test_random_drain();
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: all.f
+incdir+rtl
rtl/cu_setup_pkg.sv
rtl/cu_setup_config.sv
rtl/cu_setup_fsm.sv
rtl/serial_read_engine.sv
rtl/request_fifo.sv
rtl/cu_setup.sv
verif/tb_cu_setup.sv
